// File: tb.f
rtl/spi_pkg.sv
rtl/graphics_pkg.sv
rtl/spi_bus_if.sv
rtl/spi_peripheral.sv
rtl/spi_subperipheral_selector.sv
rtl/spi_register_chip_id.sv
rtl/graphics_command_queue.sv
rtl/top.sv
sim/tb_top.sv

// File: sim/tb_top.sv
// Directed testbench for the control FPGA, run as tb_top with an SPI host and a graphics core model
`timescale 1ns/1ps

module tb_top;
    import spi_pkg::*;
    import graphics_pkg::*;

    localparam int QUEUE_DEPTH = 16;
    localparam int DOWNSTREAM_CREDITS = 4;
    localparam int CLOCK_PERIOD = 40;
    localparam int HALF_BIT_CYCLES = 8;           // 16 system cycles per SPI bit
    localparam int CREDIT_DELAY = 5;              // Cycles from byte to returned credit
    localparam int COMMAND_TIMEOUT_CYCLES = 400;
    localparam longint WATCHDOG_NS = 40_000_000;  // Longest test needs well under 1 ms

    logic clock_18MHz_oscillator;
    logic rst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_data;
    logic spi_data_out;
    command_byte_t command_data;
    logic command_valid;
    logic command_credit;

    int errors;
    int checks;
    int first_draw;
    logic return_credits;                 // Graphics model hands credits back
    int withheld_credits;
    logic [CREDIT_DELAY-1:0] credit_pipe;

    command_byte_t received[$];           // Bytes seen on the graphics link
    command_byte_t expected[$];
    spi_byte_t tx_bytes [32];
    spi_byte_t rx_bytes [32];

    top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .DOWNSTREAM_CREDITS(DOWNSTREAM_CREDITS)
    ) DUT (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data(spi_data),
        .spi_data_out(spi_data_out),
        .command_data(command_data),
        .command_valid(command_valid),
        .command_credit(command_credit)
    );

    initial begin
        clock_18MHz_oscillator = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock_18MHz_oscillator = ~clock_18MHz_oscillator;
    end

    // Graphics core model that returns one credit per byte after a fixed delay
    always @(negedge clock_18MHz_oscillator) begin : graphics_model
        logic fire;
        fire = 1'b0;
        if (command_valid) begin
            received.push_back(command_data);
            if (return_credits) fire = 1'b1;
            else withheld_credits++;
        end else if (return_credits && withheld_credits > 0) begin
            fire = 1'b1; // Hand back credits held during a stall
            withheld_credits--;
        end
        command_credit = credit_pipe[CREDIT_DELAY-1];
        credit_pipe = {credit_pipe[CREDIT_DELAY-2:0], fire};
    end

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clock_18MHz_oscillator);
    endtask

    task automatic check_byte(input string name, input logic [7:0] actual,
                              input logic [7:0] wanted);
        checks++;
        assert (actual === wanted)
        else begin
            errors++;
            $display("FAIL %0d ns %s: got 0x%02h, expected 0x%02h", $time, name, actual, wanted);
        end
    endtask

    task automatic check_count(input string name, input int actual, input int wanted);
        checks++;
        assert (actual == wanted)
        else begin
            errors++;
            $display("FAIL %0d ns %s: got %0d, expected %0d", $time, name, actual, wanted);
        end
    endtask

    task automatic check_true(input logic condition, input string message);
        checks++;
        assert (condition)
        else begin
            errors++;
            $display("ERROR %0d ns %s", $time, message);
        end
    endtask

    // Expected status byte with overflow in bit 7 and free entries in bits 4:0
    function automatic spi_byte_t status_value(input int free_entries, input logic overflow);
        spi_byte_t value;
        value = '0;
        value[7] = overflow;
        value[4:0] = free_entries[4:0];
        return value;
    endfunction

    // Mode 0 host that sets data while the SPI clock is low
    task automatic shift_byte(input spi_byte_t out_byte, output spi_byte_t in_byte);
        for (int i = 7; i >= 0; i--) begin
            spi_data = out_byte[i];
            idle_cycles(HALF_BIT_CYCLES);
            in_byte[i] = spi_data_out; // Settled since the last falling SPI edge
            spi_clock = 1'b1;
            idle_cycles(HALF_BIT_CYCLES);
            spi_clock = 1'b0;
        end
    endtask

    task automatic spi_transaction(input spi_address_t address, input int count);
        spi_byte_t answer;
        spi_select = 1'b0;
        idle_cycles(HALF_BIT_CYCLES);
        shift_byte(address, answer);
        for (int i = 0; i < count; i++) begin
            shift_byte(tx_bytes[i], answer);
            rx_bytes[i] = answer;
        end
        idle_cycles(HALF_BIT_CYCLES);
        spi_select = 1'b1;
        idle_cycles(2 * HALF_BIT_CYCLES); // Gap between transactions
    endtask

    task automatic read_register(input spi_address_t address, input int count);
        for (int i = 0; i < count; i++) tx_bytes[i] = 8'h00;
        spi_transaction(address, count);
    endtask

    // Random payload of which only the first kept bytes are expected downstream
    task automatic write_commands(input int count, input int kept);
        for (int i = 0; i < count; i++) begin
            tx_bytes[i] = spi_byte_t'($urandom);
            if (i < kept) expected.push_back(tx_bytes[i]);
        end
        spi_transaction(GRAPHICS_COMMAND_ADDRESS, count);
    endtask

    task automatic wait_for_commands(input int count);
        int cycles;
        cycles = 0;
        while (received.size() < count && cycles < COMMAND_TIMEOUT_CYCLES) begin
            @(negedge clock_18MHz_oscillator);
            cycles++;
        end
        check_true(received.size() >= count, "timed out waiting for graphics command bytes");
    endtask

    task automatic compare_commands();
        int shared;
        check_count("command byte count", received.size(), expected.size());
        shared = (received.size() < expected.size()) ? received.size() : expected.size();
        for (int i = 0; i < shared; i++) check_byte("command_data", received[i], expected[i]);
        received.delete();
        expected.delete();
    endtask

    task automatic test_chip_id();
        read_register(CHIP_ID_ADDRESS, 2);
        check_byte("chip id first byte", rx_bytes[0], 8'h81);
        check_byte("chip id second byte", rx_bytes[1], 8'h81);
    endtask

    task automatic test_unmapped_read();
        read_register(8'h40, 2);
        check_byte("unmapped first byte", rx_bytes[0], 8'h00);
        check_byte("unmapped second byte", rx_bytes[1], 8'h00);
    endtask

    task automatic test_stream_with_credits();
        return_credits = 1'b1;
        write_commands(8, 8);
        wait_for_commands(8);
        idle_cycles(32);
        compare_commands();
    endtask

    task automatic test_credit_stall();
        return_credits = 1'b0;
        write_commands(10, 10);
        idle_cycles(64);
        check_count("forwarded bytes while stalled", received.size(), DOWNSTREAM_CREDITS);
        read_register(GRAPHICS_STATUS_ADDRESS, 1);
        check_byte("queue status", rx_bytes[0],
                   status_value(QUEUE_DEPTH - (10 - DOWNSTREAM_CREDITS), 1'b0));
        return_credits = 1'b1;
        wait_for_commands(10);
        idle_cycles(32);
        compare_commands();
    endtask

    task automatic test_overflow();
        int delivered;
        delivered = QUEUE_DEPTH + DOWNSTREAM_CREDITS;
        return_credits = 1'b0;
        write_commands(delivered + 3, delivered);
        idle_cycles(64);
        read_register(GRAPHICS_STATUS_ADDRESS, 1);
        check_byte("queue status when full", rx_bytes[0], status_value(0, 1'b1));
        return_credits = 1'b1;
        wait_for_commands(delivered);
        idle_cycles(64);
        compare_commands(); // Dropped bytes must not show up
    endtask

    initial begin
        errors = 0;
        checks = 0;
        return_credits = 1'b1;
        withheld_credits = 0;
        credit_pipe = '0;
        rst_n = 1'b0;
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_data = 1'b0;
        command_credit = 1'b0;
        first_draw = $urandom(63);

        idle_cycles(3);
        rst_n = 1'b1;
        idle_cycles(2);
        check_byte("spi_data_out after reset", spi_data_out, 1'b0);
        check_byte("command_valid after reset", command_valid, 1'b0);

        test_chip_id();
        test_unmapped_read();
        test_stream_with_credits();
        test_credit_stall();
        test_overflow();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

endmodule

// File: rtl/top.sv
// Top level of the control FPGA, connecting the SPI link and the graphics command pins
`timescale 1ns/1ps

module top #(
    parameter int QUEUE_DEPTH = 16,
    parameter int DOWNSTREAM_CREDITS = 4
) (
    input logic clock_18MHz_oscillator,
    input logic rst_n,
    input logic spi_select,
    input logic spi_clock,
    input logic spi_data,
    output logic spi_data_out,
    output graphics_pkg::command_byte_t command_data,
    output logic command_valid,
    input logic command_credit
);
    import spi_pkg::*;

    spi_bus_if bus ();

    logic chip_id_enable;
    spi_byte_t chip_id_data;
    logic chip_id_valid;

    logic queue_enable;
    logic status_enable;
    spi_byte_t queue_data;
    logic queue_valid;

    spi_peripheral spi_peripheral (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data(spi_data),
        .spi_data_out(spi_data_out),
        .bus(bus.peripheral)
    );

    spi_subperipheral_selector spi_subperipheral_selector (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .bus(bus.selector),
        .chip_id_enable(chip_id_enable),
        .chip_id_data(chip_id_data),
        .chip_id_valid(chip_id_valid),
        .queue_enable(queue_enable),
        .status_enable(status_enable),
        .queue_data(queue_data),
        .queue_valid(queue_valid)
    );

    spi_register_chip_id spi_register_chip_id (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .enable(chip_id_enable),
        .byte_strobe(bus.address_valid | bus.copi_valid),
        .data(chip_id_data),
        .data_valid(chip_id_valid)
    );

    graphics_command_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .DOWNSTREAM_CREDITS(DOWNSTREAM_CREDITS)
    ) graphics_command_queue (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .queue_enable(queue_enable),
        .status_enable(status_enable),
        .copi(bus.copi),
        .copi_valid(bus.copi_valid),
        .address_valid(bus.address_valid),
        .response(queue_data),
        .response_valid(queue_valid),
        .command_data(command_data),
        .command_valid(command_valid),
        .command_credit(command_credit)
    );

endmodule

// File: rtl/graphics_command_queue.sv
// Command FIFO from the SPI bus to the graphics core, credit flow controlled, with a status register
`timescale 1ns/1ps

module graphics_command_queue #(
    parameter int QUEUE_DEPTH = 16,
    parameter int DOWNSTREAM_CREDITS = 4
) (
    input logic clock_18MHz_oscillator,
    input logic rst_n,
    input logic queue_enable,
    input logic status_enable,
    input spi_pkg::spi_byte_t copi,
    input logic copi_valid,
    input logic address_valid,
    output spi_pkg::spi_byte_t response,
    output logic response_valid,
    output graphics_pkg::command_byte_t command_data,
    output logic command_valid,
    input logic command_credit
);
    import spi_pkg::*;
    import graphics_pkg::*;

    localparam int POINTER_WIDTH = $clog2(QUEUE_DEPTH);

    command_byte_t entries [QUEUE_DEPTH];
    logic [POINTER_WIDTH-1:0] write_pointer;
    logic [POINTER_WIDTH-1:0] read_pointer;

    queue_count_t fill_count;
    queue_count_t free_count;
    queue_count_t credit_count;
    logic overflow;               // Sticky until reset

    logic write_request;
    logic full;
    logic push;
    logic pop;
    logic status_strobe;
    spi_byte_t status_byte;

    assign write_request = queue_enable & copi_valid;
    assign full = fill_count == queue_count_t'(QUEUE_DEPTH);
    assign push = write_request & ~full;
    assign pop = (fill_count != '0) && (credit_count != '0); // Forward only with a credit in hand
    assign free_count = queue_count_t'(QUEUE_DEPTH) - fill_count;

    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            write_pointer <= '0;
            read_pointer <= '0;
            fill_count <= '0;
            credit_count <= queue_count_t'(DOWNSTREAM_CREDITS);
            overflow <= 1'b0;
            command_valid <= 1'b0;
        end else begin
            command_valid <= pop;

            if (push) write_pointer <= write_pointer + 1'b1;
            if (pop) read_pointer <= read_pointer + 1'b1;

            case ({push, pop})
                2'b10: fill_count <= fill_count + 1'b1;
                2'b01: fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;
            endcase

            // A returned credit and a spent one may land together
            case ({command_credit, pop})
                2'b10: credit_count <= credit_count + 1'b1;
                2'b01: credit_count <= credit_count - 1'b1;
                default: credit_count <= credit_count;
            endcase

            if (write_request && full) overflow <= 1'b1; // Byte dropped
        end
    end

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (push) entries[write_pointer] <= copi;
        if (pop) command_data <= entries[read_pointer];
    end

    // Status register
    assign status_strobe = status_enable & (address_valid | copi_valid);

    always_comb begin
        status_byte = '0;
        status_byte[STATUS_OVERFLOW_BIT] = overflow;
        status_byte[STATUS_FREE_WIDTH-1:0] = free_count;
    end

    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            response_valid <= 1'b0;
        end else begin
            response_valid <= status_strobe;
        end
    end

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (status_strobe) response <= status_byte; // Snapshot at the strobe
    end

endmodule

// File: rtl/spi_register_chip_id.sv
// Read-only chip identity register on the SPI byte bus
`timescale 1ns/1ps

module spi_register_chip_id (
    input logic clock_18MHz_oscillator,
    input logic rst_n,
    input logic enable,
    input logic byte_strobe,
    output spi_pkg::spi_byte_t data,
    output logic data_valid
);
    import spi_pkg::*;

    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= enable & byte_strobe; // One pulse per strobe
        end
    end

    // Identity byte loaded alongside each answer
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (enable && byte_strobe) data <= CHIP_ID_VALUE;
    end

endmodule

// File: rtl/spi_subperipheral_selector.sv
// Address decoder that enables one peer register and routes its answer back to the peripheral
`timescale 1ns/1ps

module spi_subperipheral_selector (
    input logic clock_18MHz_oscillator,
    input logic rst_n,
    spi_bus_if.selector bus,
    output logic chip_id_enable,
    input spi_pkg::spi_byte_t chip_id_data,
    input logic chip_id_valid,
    output logic queue_enable,
    output logic status_enable,
    input spi_pkg::spi_byte_t queue_data,
    input logic queue_valid
);
    import spi_pkg::*;

    spi_address_t address_q;      // Address of the open transaction
    spi_address_t active_address;
    logic unmapped;
    logic unmapped_valid;         // Zero answer for unknown addresses

    // New address takes effect in its own strobe cycle so peers can answer in time
    assign active_address = bus.address_valid ? bus.address : address_q;

    assign chip_id_enable = active_address == CHIP_ID_ADDRESS;
    assign queue_enable = active_address == GRAPHICS_COMMAND_ADDRESS;
    assign status_enable = active_address == GRAPHICS_STATUS_ADDRESS;
    assign unmapped = ~(chip_id_enable | queue_enable | status_enable);

    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            address_q <= '0;
            unmapped_valid <= 1'b0;
        end else begin
            if (bus.address_valid) address_q <= bus.address;
            unmapped_valid <= unmapped & (bus.address_valid | bus.copi_valid);
        end
    end

    // Response mux
    always_comb begin
        if (chip_id_enable) begin
            bus.cipo = chip_id_data;
            bus.cipo_valid = chip_id_valid;
        end else if (queue_enable || status_enable) begin
            bus.cipo = queue_data;
            bus.cipo_valid = queue_valid;
        end else begin
            bus.cipo = '0;
            bus.cipo_valid = unmapped_valid;
        end
    end

endmodule

// File: rtl/spi_peripheral.sv
// SPI mode 0 peripheral: synchronizes the pins and turns the link into address and data strobes
`timescale 1ns/1ps

module spi_peripheral (
    input logic clock_18MHz_oscillator,
    input logic rst_n,
    input logic spi_select,
    input logic spi_clock,
    input logic spi_data,
    output logic spi_data_out,
    spi_bus_if.peripheral bus
);
    import spi_pkg::*;

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_ADDRESS,
        STATE_DATA
    } spi_state_t;

    spi_state_t state;

    // Two-flop synchronizers for the pins
    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic clock_last;          // Previous synchronized SPI clock

    logic select_active;
    logic spi_rise;
    logic spi_fall;

    logic [2:0] bit_count;     // Rising edges seen in the current byte
    spi_byte_t rx_shift;
    spi_byte_t rx_byte;
    spi_byte_t tx_shift;

    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            select_sync <= 2'b11;  // Deselected
            clock_sync <= 2'b00;
            data_sync <= 2'b00;
            clock_last <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync <= {clock_sync[0], spi_clock};
            data_sync <= {data_sync[0], spi_data};
            clock_last <= clock_sync[1];
        end
    end

    assign select_active = ~select_sync[1];
    assign spi_rise = clock_sync[1] & ~clock_last;
    assign spi_fall = ~clock_sync[1] & clock_last;

    // Byte as it stands once the current bit is shifted in
    assign rx_byte = {rx_shift[6:0], data_sync[1]};

    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            state <= STATE_IDLE;
            bit_count <= '0;
            rx_shift <= '0;
            tx_shift <= '0;
            bus.address <= '0;
            bus.address_valid <= 1'b0;
            bus.copi <= '0;
            bus.copi_valid <= 1'b0;
        end else begin
            bus.address_valid <= 1'b0;
            bus.copi_valid <= 1'b0;

            if (!select_active) begin
                state <= STATE_IDLE;
                bit_count <= '0;
                tx_shift <= '0;
            end else begin
                if (state == STATE_IDLE) state <= STATE_ADDRESS;

                // Sample COPI on rising edges
                if (spi_rise) begin
                    rx_shift <= rx_byte;
                    bit_count <= bit_count + 3'd1;

                    if (bit_count == 3'd7) begin
                        if (state == STATE_DATA) begin
                            bus.copi <= rx_byte;
                            bus.copi_valid <= 1'b1;
                        end else begin
                            bus.address <= rx_byte;
                            bus.address_valid <= 1'b1;
                            state <= STATE_DATA;
                        end
                        tx_shift <= '0; // Sent as zero unless a peer answers
                    end
                end

                // Falling edge that closes a byte keeps the next MSB on the line
                if (spi_fall && bit_count != 3'd0) begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end

                if (bus.cipo_valid) tx_shift <= bus.cipo;
            end
        end
    end

    assign spi_data_out = tx_shift[7];

endmodule

// File: rtl/spi_bus_if.sv
// Byte bus between the SPI peripheral and the address selector, one side per modport
`timescale 1ns/1ps

interface spi_bus_if;
    import spi_pkg::*;

    // Host to chip
    spi_address_t address;      // Held after the address byte
    logic address_valid;        // One cycle, first byte of a transaction
    spi_byte_t copi;
    logic copi_valid;           // One cycle per later byte

    // Chip to host
    spi_byte_t cipo;
    logic cipo_valid;           // Loads the byte for the next shift-out

    modport peripheral (
        output address,
        output address_valid,
        output copi,
        output copi_valid,
        input cipo,
        input cipo_valid
    );

    modport selector (
        input address,
        input address_valid,
        input copi,
        input copi_valid,
        output cipo,
        output cipo_valid
    );

endinterface

// File: rtl/graphics_pkg.sv
// Graphics command queue types and status layout, shared by the queue, the top level and the testbench
package graphics_pkg;

    // One command or operand byte handed to the graphics core
    typedef logic [7:0] command_byte_t;

    // Entry or credit count, wide enough for a queue of up to 16 entries
    typedef logic [4:0] queue_count_t;

    // Status byte layout at the status address
    //   bit 7     sticky overflow, set when a write hits a full queue
    //   bits 6:5  zero
    //   bits 4:0  free entries
    localparam int STATUS_OVERFLOW_BIT = 7;
    localparam int STATUS_FREE_WIDTH = $bits(queue_count_t);

    // Graphics link
    //   command_valid pulses once per byte and spends one credit
    //   command_credit pulses once per credit returned by the core

endpackage

// File: rtl/spi_pkg.sv
// SPI byte-bus types and the register map, imported by the peripheral, selector and registers
package spi_pkg;

    // One byte as shifted over the link, in either direction
    typedef logic [7:0] spi_byte_t;

    // Register address, always the first byte of a transaction
    typedef logic [7:0] spi_address_t;

    // Register map
    localparam spi_address_t CHIP_ID_ADDRESS = 8'hDB;
    localparam spi_address_t GRAPHICS_COMMAND_ADDRESS = 8'h12; // Write-only queue input
    localparam spi_address_t GRAPHICS_STATUS_ADDRESS = 8'h13; // Read-only queue status

    // Fixed identity returned from CHIP_ID_ADDRESS
    localparam spi_byte_t CHIP_ID_VALUE = 8'h81;

    // Any address not listed above reads as zero and swallows writes

endpackage
